/* otp_cfg.f */
+incdir+design
design/otp_cfg_pkg.sv
design/cfg_bus_if.sv
design/apb_cfg_decoder.sv
design/converter_cfg_regs.sv
design/sequencer_cfg_regs.sv
design/cfg_read_mux.sv
design/otp_cfg_top.sv
verif/tb_otp_cfg.sv

/* verif/tb_otp_cfg.sv */
`timescale 1ns/100ps
`default_nettype none

`include "otp_cfg_defines.svh"

module tb_otp_cfg;
    import otp_cfg_pkg::*;

    localparam int NUM_REGS   = 10;
    localparam int MAX_CYCLES = 2000; // Several times the length of the stimulus below.

    // Kept registers in map order, with the bits each one stores.
    localparam apb_addr_t REG_OFS [NUM_REGS] = '{
        `OTP_VPRE_1_OFS, `OTP_VPRE_2_OFS, `OTP_VPRE_3_OFS, `OTP_BOOST_1_OFS,
        `OTP_BOOST_2_OFS, `OTP_BOOST_3_OFS, `OTP_LDO_OFS, `OTP_SEQ_1_OFS,
        `OTP_SEQ_2_OFS, `OTP_SEQ_3_OFS
    };
    localparam cfg_byte_t REG_MASK [NUM_REGS] = '{
        8'h3F, 8'h3F, 8'hC3, 8'h2F, 8'hFF, 8'h03, 8'hFF, 8'h3F, 8'h3F, 8'hFF
    };
    // Just below, just above, far below, index alias and a wrapped address.
    localparam apb_addr_t OUTSIDE [5] = '{
        32'h0000_0093, 32'h0000_00AE, 32'h0000_0000, 32'h0000_0194, 32'hFFFF_FF94
    };

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    cfg_byte_t  pwdata;
    cfg_byte_t  prdata;
    trim6_t     vprev;
    trim6_t     vpresc;
    sel2_t      vpresrhs;
    sel2_t      vpreilim;
    logic [3:0] vbstv;
    logic       vpre_mode;
    logic [4:0] vbstsc;
    sel2_t      vbsttontime;
    logic       boosten;
    sel2_t      vbstsr;
    slot3_t     ldo1v;
    logic       ldo1ilim;
    slot3_t     ldo2v;
    logic       ldo2ilim;
    slot3_t     vb1s;
    slot3_t     vb2s;
    slot3_t     ldo1s;
    slot3_t     ldo2s;
    slot3_t     vb3s;
    logic       tslot;
    sel2_t      dvs_buck3;
    sel2_t      dvs_buck12;

    cfg_byte_t  model [NUM_REGS];
    integer     seed;
    int         errors;
    int         cycles;

    otp_cfg_top dut_i (.*);

    always #2 clk = ~clk;

    //////////////////////
    // Reference model
    //////////////////////

    function automatic cfg_byte_t expected_rdata(input logic sel, input apb_addr_t addr);
        cfg_byte_t result;
        result = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (sel && addr == `OTP_CFG_BASE + REG_OFS[i]) begin
                result = model[i];
            end
        end
        return result;
    endfunction

    task automatic report_mismatch(input string what);
        errors++;
        $display("CHECK FAILED at %0t: %s does not match the model", $time, what);
    endtask

    // Called after the commit edge, so the model moves with the DUT.
    task automatic update_model(input apb_addr_t addr, input cfg_byte_t data);
        for (int i = 0; i < NUM_REGS; i++) begin
            if (addr == `OTP_CFG_BASE + REG_OFS[i]) begin
                model[i] = data & REG_MASK[i];
            end
        end
    endtask

    //////////////////////
    // Checks
    //////////////////////

    assert property (@(posedge clk) prdata == expected_rdata(psel, paddr))
        else report_mismatch("prdata");
    assert property (@(posedge clk) vprev == model[0][5:0])
        else report_mismatch("VPRE_1 fields");
    assert property (@(posedge clk) vpresc == model[1][5:0])
        else report_mismatch("VPRE_2 fields");
    assert property (@(posedge clk) {vpreilim, vpresrhs} == {model[2][7:6], model[2][1:0]})
        else report_mismatch("VPRE_3 fields");
    assert property (@(posedge clk) {vpre_mode, vbstv} == {model[3][5], model[3][3:0]})
        else report_mismatch("BOOST_1 fields");
    assert property (@(posedge clk)
        {boosten, vbsttontime, vbstsc} == {model[4][7], model[4][6:5], model[4][4:0]})
        else report_mismatch("BOOST_2 fields");
    assert property (@(posedge clk) vbstsr == model[5][1:0])
        else report_mismatch("BOOST_3 fields");
    assert property (@(posedge clk)
        {ldo2ilim, ldo2v, ldo1ilim, ldo1v} == {model[6][7], model[6][6:4], model[6][3],
        model[6][2:0]})
        else report_mismatch("LDO fields");
    assert property (@(posedge clk) {vb2s, vb1s} == {model[7][5:3], model[7][2:0]})
        else report_mismatch("SEQ_1 fields");
    assert property (@(posedge clk) {ldo2s, ldo1s} == {model[8][5:3], model[8][2:0]})
        else report_mismatch("SEQ_2 fields");
    assert property (@(posedge clk)
        {dvs_buck12, dvs_buck3, tslot, vb3s} == {model[9][7:6], model[9][5:4], model[9][3],
        model[9][2:0]})
        else report_mismatch("SEQ_3 fields");

    //////////////////////
    // APB stimulus
    //////////////////////

    task automatic apb_write(input apb_addr_t addr, input cfg_byte_t data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        update_model(addr, data);
    endtask

    task automatic apb_read(input apb_addr_t addr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Setup phase of a write with no access phase after it.
    task automatic setup_only_write(input apb_addr_t addr, input cfg_byte_t data);
        @(negedge clk);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        @(negedge clk);
        psel   = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_then_read(input apb_addr_t addr, input cfg_byte_t data);
        apb_write(addr, data);
        apb_read(addr);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks finished with %0d errors", errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        seed    = 32'h6006214a;
        errors  = 0;
        cycles  = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_REGS; i++) begin
            apb_read(`OTP_CFG_BASE + REG_OFS[i]);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            write_then_read(`OTP_CFG_BASE + REG_OFS[i], cfg_byte_t'($random(seed)));
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            write_then_read(`OTP_CFG_BASE + REG_OFS[i], 8'hFF);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            write_then_read(`OTP_CFG_BASE + REG_OFS[i], cfg_byte_t'($random(seed)));
        end

        // Holes inside the window.
        for (int ofs = 'h1A; ofs <= 'h2D; ofs++) begin
            if (ofs <= 'h1F || ofs >= 'h24) begin
                write_then_read(`OTP_CFG_BASE + apb_addr_t'(ofs), cfg_byte_t'($random(seed)));
            end
        end
        for (int i = 0; i < 5; i++) begin
            write_then_read(OUTSIDE[i], cfg_byte_t'($random(seed)));
        end

        for (int i = 0; i < NUM_REGS; i++) begin
            setup_only_write(`OTP_CFG_BASE + REG_OFS[i], ~model[i]);
            apb_read(`OTP_CFG_BASE + REG_OFS[i]);
        end
        // Idle bus parked on each register address.
        for (int i = 0; i < NUM_REGS; i++) begin
            @(negedge clk);
            paddr = `OTP_CFG_BASE + REG_OFS[i];
        end

        repeat (2) @(negedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/otp_cfg_top.sv */
`timescale 1ns/100ps
`default_nettype none

module otp_cfg_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  otp_cfg_pkg::apb_addr_t paddr,
    input  otp_cfg_pkg::cfg_byte_t pwdata,
    output otp_cfg_pkg::cfg_byte_t prdata,
    output otp_cfg_pkg::trim6_t    vprev,
    output otp_cfg_pkg::trim6_t    vpresc,
    output otp_cfg_pkg::sel2_t     vpresrhs,
    output otp_cfg_pkg::sel2_t     vpreilim,
    output logic [3:0]             vbstv,
    output logic                   vpre_mode,
    output logic [4:0]             vbstsc,
    output otp_cfg_pkg::sel2_t     vbsttontime,
    output logic                   boosten,
    output otp_cfg_pkg::sel2_t     vbstsr,
    output otp_cfg_pkg::slot3_t    ldo1v,
    output logic                   ldo1ilim,
    output otp_cfg_pkg::slot3_t    ldo2v,
    output logic                   ldo2ilim,
    output otp_cfg_pkg::slot3_t    vb1s,
    output otp_cfg_pkg::slot3_t    vb2s,
    output otp_cfg_pkg::slot3_t    ldo1s,
    output otp_cfg_pkg::slot3_t    ldo2s,
    output otp_cfg_pkg::slot3_t    vb3s,
    output logic                   tslot,
    output otp_cfg_pkg::sel2_t     dvs_buck3,
    output otp_cfg_pkg::sel2_t     dvs_buck12
);
    import otp_cfg_pkg::*;

    cfg_byte_t vpre1_rb;
    cfg_byte_t vpre2_rb;
    cfg_byte_t vpre3_rb;
    cfg_byte_t boost1_rb;
    cfg_byte_t boost2_rb;
    cfg_byte_t boost3_rb;
    cfg_byte_t ldo_rb;
    cfg_byte_t seq1_rb;
    cfg_byte_t seq2_rb;
    cfg_byte_t seq3_rb;

    cfg_bus_if cfg_bus ();

    apb_cfg_decoder decoder_i (
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .bus(cfg_bus.decoder)
    );

    converter_cfg_regs converter_i (
        .clk(clk), .rst_n(rst_n), .bus(cfg_bus.bank),
        .vprev(vprev), .vpresc(vpresc), .vpresrhs(vpresrhs), .vpreilim(vpreilim),
        .vbstv(vbstv), .vpre_mode(vpre_mode), .vbstsc(vbstsc),
        .vbsttontime(vbsttontime), .boosten(boosten), .vbstsr(vbstsr),
        .vpre1_rb(vpre1_rb), .vpre2_rb(vpre2_rb), .vpre3_rb(vpre3_rb),
        .boost1_rb(boost1_rb), .boost2_rb(boost2_rb), .boost3_rb(boost3_rb)
    );

    sequencer_cfg_regs sequencer_i (
        .clk(clk), .rst_n(rst_n), .bus(cfg_bus.bank),
        .ldo1v(ldo1v), .ldo1ilim(ldo1ilim), .ldo2v(ldo2v), .ldo2ilim(ldo2ilim),
        .vb1s(vb1s), .vb2s(vb2s), .ldo1s(ldo1s), .ldo2s(ldo2s),
        .vb3s(vb3s), .tslot(tslot), .dvs_buck3(dvs_buck3), .dvs_buck12(dvs_buck12),
        .ldo_rb(ldo_rb), .seq1_rb(seq1_rb), .seq2_rb(seq2_rb), .seq3_rb(seq3_rb)
    );

    cfg_read_mux read_mux_i (
        .bus(cfg_bus.readback),
        .vpre1_rb(vpre1_rb), .vpre2_rb(vpre2_rb), .vpre3_rb(vpre3_rb),
        .boost1_rb(boost1_rb), .boost2_rb(boost2_rb), .boost3_rb(boost3_rb),
        .ldo_rb(ldo_rb), .seq1_rb(seq1_rb), .seq2_rb(seq2_rb), .seq3_rb(seq3_rb),
        .prdata(prdata)
    );

endmodule

`default_nettype wire

/* design/cfg_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "otp_cfg_defines.svh"

module cfg_read_mux (
    cfg_bus_if.readback            bus,
    input  otp_cfg_pkg::cfg_byte_t vpre1_rb,
    input  otp_cfg_pkg::cfg_byte_t vpre2_rb,
    input  otp_cfg_pkg::cfg_byte_t vpre3_rb,
    input  otp_cfg_pkg::cfg_byte_t boost1_rb,
    input  otp_cfg_pkg::cfg_byte_t boost2_rb,
    input  otp_cfg_pkg::cfg_byte_t boost3_rb,
    input  otp_cfg_pkg::cfg_byte_t ldo_rb,
    input  otp_cfg_pkg::cfg_byte_t seq1_rb,
    input  otp_cfg_pkg::cfg_byte_t seq2_rb,
    input  otp_cfg_pkg::cfg_byte_t seq3_rb,
    output otp_cfg_pkg::cfg_byte_t prdata
);
    import otp_cfg_pkg::*;

    always_comb begin
        prdata = '0; // Misses, holes and idle bus read zero.
        if (bus.hit) begin
            case (bus.idx)
                reg_idx_t'(`OTP_VPRE_1_OFS - `OTP_CFG_FIRST):  prdata = vpre1_rb;
                reg_idx_t'(`OTP_VPRE_2_OFS - `OTP_CFG_FIRST):  prdata = vpre2_rb;
                reg_idx_t'(`OTP_VPRE_3_OFS - `OTP_CFG_FIRST):  prdata = vpre3_rb;
                reg_idx_t'(`OTP_BOOST_1_OFS - `OTP_CFG_FIRST): prdata = boost1_rb;
                reg_idx_t'(`OTP_BOOST_2_OFS - `OTP_CFG_FIRST): prdata = boost2_rb;
                reg_idx_t'(`OTP_BOOST_3_OFS - `OTP_CFG_FIRST): prdata = boost3_rb;
                reg_idx_t'(`OTP_LDO_OFS - `OTP_CFG_FIRST):     prdata = ldo_rb;
                reg_idx_t'(`OTP_SEQ_1_OFS - `OTP_CFG_FIRST):   prdata = seq1_rb;
                reg_idx_t'(`OTP_SEQ_2_OFS - `OTP_CFG_FIRST):   prdata = seq2_rb;
                reg_idx_t'(`OTP_SEQ_3_OFS - `OTP_CFG_FIRST):   prdata = seq3_rb;
                default: prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/sequencer_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "otp_cfg_defines.svh"

module sequencer_cfg_regs (
    input  wire                    clk,
    input  wire                    rst_n,
    cfg_bus_if.bank                bus,
    output otp_cfg_pkg::slot3_t    ldo1v,
    output logic                   ldo1ilim,
    output otp_cfg_pkg::slot3_t    ldo2v,
    output logic                   ldo2ilim,
    output otp_cfg_pkg::slot3_t    vb1s,
    output otp_cfg_pkg::slot3_t    vb2s,
    output otp_cfg_pkg::slot3_t    ldo1s,
    output otp_cfg_pkg::slot3_t    ldo2s,
    output otp_cfg_pkg::slot3_t    vb3s,
    output logic                   tslot,
    output otp_cfg_pkg::sel2_t     dvs_buck3,
    output otp_cfg_pkg::sel2_t     dvs_buck12,
    output otp_cfg_pkg::cfg_byte_t ldo_rb,
    output otp_cfg_pkg::cfg_byte_t seq1_rb,
    output otp_cfg_pkg::cfg_byte_t seq2_rb,
    output otp_cfg_pkg::cfg_byte_t seq3_rb
);
    import otp_cfg_pkg::*;

    localparam reg_idx_t LDO_IDX   = reg_idx_t'(`OTP_LDO_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t SEQ_1_IDX = reg_idx_t'(`OTP_SEQ_1_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t SEQ_2_IDX = reg_idx_t'(`OTP_SEQ_2_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t SEQ_3_IDX = reg_idx_t'(`OTP_SEQ_3_OFS - `OTP_CFG_FIRST);

    logic wr_ldo;
    logic wr_seq1;
    logic wr_seq2;
    logic wr_seq3;

    assign wr_ldo  = bus.wr_en && (bus.idx == LDO_IDX);
    assign wr_seq1 = bus.wr_en && (bus.idx == SEQ_1_IDX);
    assign wr_seq2 = bus.wr_en && (bus.idx == SEQ_2_IDX);
    assign wr_seq3 = bus.wr_en && (bus.idx == SEQ_3_IDX);

    ////////////////////
    // LDO and sequencing fields
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {ldo2ilim, ldo2v, ldo1ilim, ldo1v} <= '0;
            {vb2s, vb1s}                       <= '0;
            {ldo2s, ldo1s}                     <= '0;
            {dvs_buck12, dvs_buck3, tslot, vb3s} <= '0;
        end else begin
            if (wr_ldo) begin
                {ldo2ilim, ldo2v, ldo1ilim, ldo1v} <= bus.wdata; // All eight bits used.
            end
            if (wr_seq1) begin
                {vb2s, vb1s} <= bus.wdata[5:0];
            end
            if (wr_seq2) begin
                {ldo2s, ldo1s} <= bus.wdata[5:0];
            end
            if (wr_seq3) begin
                {dvs_buck12, dvs_buck3, tslot, vb3s} <= bus.wdata;
            end
        end
    end

    assign ldo_rb  = {ldo2ilim, ldo2v, ldo1ilim, ldo1v};
    assign seq1_rb = {2'b00, vb2s, vb1s};   // Top two bits read zero.
    assign seq2_rb = {2'b00, ldo2s, ldo1s};
    assign seq3_rb = {dvs_buck12, dvs_buck3, tslot, vb3s};

endmodule

`default_nettype wire

/* design/converter_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "otp_cfg_defines.svh"

module converter_cfg_regs (
    input  wire                    clk,
    input  wire                    rst_n,
    cfg_bus_if.bank                bus,
    output otp_cfg_pkg::trim6_t    vprev,
    output otp_cfg_pkg::trim6_t    vpresc,
    output otp_cfg_pkg::sel2_t     vpresrhs,
    output otp_cfg_pkg::sel2_t     vpreilim,
    output logic [3:0]             vbstv,
    output logic                   vpre_mode,
    output logic [4:0]             vbstsc,
    output otp_cfg_pkg::sel2_t     vbsttontime,
    output logic                   boosten,
    output otp_cfg_pkg::sel2_t     vbstsr,
    output otp_cfg_pkg::cfg_byte_t vpre1_rb,
    output otp_cfg_pkg::cfg_byte_t vpre2_rb,
    output otp_cfg_pkg::cfg_byte_t vpre3_rb,
    output otp_cfg_pkg::cfg_byte_t boost1_rb,
    output otp_cfg_pkg::cfg_byte_t boost2_rb,
    output otp_cfg_pkg::cfg_byte_t boost3_rb
);
    import otp_cfg_pkg::*;

    localparam reg_idx_t VPRE_1_IDX  = reg_idx_t'(`OTP_VPRE_1_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t VPRE_2_IDX  = reg_idx_t'(`OTP_VPRE_2_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t VPRE_3_IDX  = reg_idx_t'(`OTP_VPRE_3_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t BOOST_1_IDX = reg_idx_t'(`OTP_BOOST_1_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t BOOST_2_IDX = reg_idx_t'(`OTP_BOOST_2_OFS - `OTP_CFG_FIRST);
    localparam reg_idx_t BOOST_3_IDX = reg_idx_t'(`OTP_BOOST_3_OFS - `OTP_CFG_FIRST);

    logic wr_vpre1;
    logic wr_vpre2;
    logic wr_vpre3;
    logic wr_boost1;
    logic wr_boost2;
    logic wr_boost3;

    assign wr_vpre1  = bus.wr_en && (bus.idx == VPRE_1_IDX);
    assign wr_vpre2  = bus.wr_en && (bus.idx == VPRE_2_IDX);
    assign wr_vpre3  = bus.wr_en && (bus.idx == VPRE_3_IDX);
    assign wr_boost1 = bus.wr_en && (bus.idx == BOOST_1_IDX);
    assign wr_boost2 = bus.wr_en && (bus.idx == BOOST_2_IDX);
    assign wr_boost3 = bus.wr_en && (bus.idx == BOOST_3_IDX);

    ////////////////////
    // Pre-regulator fields
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vprev    <= '0;
            vpresc   <= '0;
            vpresrhs <= '0;
            vpreilim <= '0;
        end else begin
            if (wr_vpre1) begin
                vprev <= bus.wdata[5:0];
            end
            if (wr_vpre2) begin
                vpresc <= bus.wdata[5:0];
            end
            if (wr_vpre3) begin
                vpresrhs <= bus.wdata[1:0];
                vpreilim <= bus.wdata[7:6]; // Bits 5:2 are not stored.
            end
        end
    end

    ////////////////////
    // Boost fields
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vbstv       <= '0;
            vpre_mode   <= 1'b0;
            vbstsc      <= '0;
            vbsttontime <= '0;
            boosten     <= 1'b0;
            vbstsr      <= '0;
        end else begin
            if (wr_boost1) begin
                vbstv     <= bus.wdata[3:0];
                vpre_mode <= bus.wdata[5];
            end
            if (wr_boost2) begin
                vbstsc      <= bus.wdata[4:0];
                vbsttontime <= bus.wdata[6:5];
                boosten     <= bus.wdata[7];
            end
            if (wr_boost3) begin
                vbstsr <= bus.wdata[1:0];
            end
        end
    end

    // Unused bits read back as zero.
    assign vpre1_rb  = {2'b00, vprev};
    assign vpre2_rb  = {2'b00, vpresc};
    assign vpre3_rb  = {vpreilim, 4'b0000, vpresrhs};
    assign boost1_rb = {2'b00, vpre_mode, 1'b0, vbstv};
    assign boost2_rb = {boosten, vbsttontime, vbstsc};
    assign boost3_rb = {6'b00_0000, vbstsr};

endmodule

`default_nettype wire

/* design/apb_cfg_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "otp_cfg_defines.svh"

module apb_cfg_decoder (
    input  wire                    psel,
    input  wire                    penable,
    input  wire                    pwrite,
    input  otp_cfg_pkg::apb_addr_t paddr,
    input  otp_cfg_pkg::cfg_byte_t pwdata,
    cfg_bus_if.decoder             bus
);
    import otp_cfg_pkg::*;

    apb_addr_t win_ofs;
    logic      win_hit;

    ////////////////////
    // Window check
    ////////////////////

    // An address below the window wraps to a large offset and misses.
    assign win_ofs = paddr - (`OTP_CFG_BASE + `OTP_CFG_FIRST);
    assign win_hit = psel && (win_ofs < `OTP_CFG_WIN_SIZE);

    ////////////////////
    // Access to the banks
    ////////////////////

    assign bus.hit   = win_hit;
    assign bus.idx   = win_ofs[`OTP_CFG_IDX_W-1:0];
    assign bus.wr_en = win_hit && pwrite && penable; // Access phase only.
    assign bus.wdata = pwdata;

endmodule

`default_nettype wire

/* design/cfg_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface cfg_bus_if;
    import otp_cfg_pkg::*;

    logic      hit;   // Access falls inside the OTP window.
    logic      wr_en; // Write commits at the next clock edge.
    reg_idx_t  idx;
    cfg_byte_t wdata;

    modport decoder (
        output hit,
        output wr_en,
        output idx,
        output wdata
    );

    modport bank (
        input wr_en,
        input idx,
        input wdata
    );

    modport readback (
        input hit,
        input idx
    );

endinterface

`default_nettype wire

/* design/otp_cfg_pkg.sv */
`default_nettype none

`include "otp_cfg_defines.svh"

package otp_cfg_pkg;

    // APB address as seen on paddr.
    typedef logic [31:0] apb_addr_t;

    // One configuration register or APB data byte.
    typedef logic [`OTP_CFG_DATA_W-1:0] cfg_byte_t;

    // Register index, offset minus the first register offset.
    typedef logic [`OTP_CFG_IDX_W-1:0] reg_idx_t;

    // Voltage or slope trim code.
    typedef logic [5:0] trim6_t;

    // Option code for current limits, slew rate, on-time and DVS.
    typedef logic [1:0] sel2_t;

    // Sequencing slot or LDO voltage code.
    typedef logic [2:0] slot3_t;

endpackage

`default_nettype wire

/* design/otp_cfg_defines.svh */
`ifndef OTP_CFG_DEFINES_SVH
`define OTP_CFG_DEFINES_SVH

// OTP configuration window on the APB map.
`define OTP_CFG_BASE        32'h0000_0080
`define OTP_CFG_FIRST       32'h0000_0014
`define OTP_CFG_LAST        32'h0000_002D
`define OTP_CFG_WIN_SIZE    (`OTP_CFG_LAST - `OTP_CFG_FIRST + 32'd1)

// Register offsets above the window base.
`define OTP_VPRE_1_OFS      32'h0000_0014
`define OTP_VPRE_2_OFS      32'h0000_0015
`define OTP_VPRE_3_OFS      32'h0000_0016
`define OTP_BOOST_1_OFS     32'h0000_0017
`define OTP_BOOST_2_OFS     32'h0000_0018
`define OTP_BOOST_3_OFS     32'h0000_0019
`define OTP_LDO_OFS         32'h0000_0020
`define OTP_SEQ_1_OFS       32'h0000_0021
`define OTP_SEQ_2_OFS       32'h0000_0022
`define OTP_SEQ_3_OFS       32'h0000_0023

// Register byte width and index width.
`define OTP_CFG_DATA_W      8
`define OTP_CFG_IDX_W       5

`endif
